// File: src/radio_defines.svh
/*
  Shared constants of the radio datapath
  Settings and readback addresses are 8 bits wide
  Response codes sit in the top byte of the 64-bit response word
*/
`ifndef RADIO_DEFINES_SVH
`define RADIO_DEFINES_SVH

// Field widths
`define RADIO_SAMPLE_W 32
`define RADIO_TIME_W 64
`define RADIO_SID_W 16
`define RADIO_LEN_W 16
`define RADIO_ADDR_W 8
`define RADIO_CODE_W 8
`define RADIO_RB_W 64

// Settings bus addresses
`define RADIO_SR_LOOPBACK 8'd130
`define RADIO_SR_TEST 8'd131
`define RADIO_SR_IDLE 8'd132
`define RADIO_SR_RX_CMD 8'd152
`define RADIO_SR_RX_MAXLEN 8'd157

// Readback addresses
`define RADIO_RB_TIME 8'd0
`define RADIO_RB_TEST 8'd2
`define RADIO_RB_TXRX 8'd3
`define RADIO_RB_NUM 8'd4

// Response codes
`define RADIO_RESP_ACK 8'h00
`define RADIO_RESP_UNDERFLOW 8'h01
`define RADIO_RESP_OVERFLOW 8'h08

`define RADIO_NUM_DEFAULT 0

`endif

// File: src/radio_sample_pkg.sv
/*
  Sample side types of the radio datapath
  A sample packs I in the upper and Q in the lower 16 bits
*/
`include "radio_defines.svh"

package radio_sample_pkg;

  // One I/Q sample
  typedef logic [`RADIO_SAMPLE_W-1:0] sample_t;

  // Free running VITA time
  typedef logic [`RADIO_TIME_W-1:0] vita_time_t;

  typedef logic [`RADIO_SID_W-1:0] sid_t;

  // Sample count of a capture or a packet
  typedef logic [`RADIO_LEN_W-1:0] len_t;

endpackage

// File: src/radio_ctrl_pkg.sv
/*
  Control side types of the radio datapath
  Response word carries only the low 24 bits of the event time
*/
`include "radio_defines.svh"

package radio_ctrl_pkg;

  // Settings bus write
  typedef struct packed {
    logic                     stb;
    logic [`RADIO_ADDR_W-1:0] addr;
    logic [31:0]              data;
  } set_bus_t;

  // Decoded configuration shared by TX and RX
  typedef struct packed {
    logic                      loopback;
    radio_sample_pkg::sample_t idle;
    radio_sample_pkg::len_t    maxlen;
    logic [31:0]               test;
  } radio_cfg_t;

  // 64-bit response word, code in the top byte
  typedef struct packed {
    logic [`RADIO_CODE_W-1:0] code;
    radio_sample_pkg::sid_t   src;
    radio_sample_pkg::sid_t   dst;
    logic [23:0]              time_lo;
  } resp_t;

  typedef enum logic [1:0] {TX_IDLE, TX_RUN, TX_RESP} tx_state_t;

  typedef enum logic [1:0] {RX_IDLE, RX_RUN, RX_RESP} rx_state_t;

endpackage

// File: src/radio_settings.sv
/*
  Configuration registers and readback multiplexer
  Writes land on the edge that samples the strobe
  Readback is combinational, strobe low for unknown addresses
  RX command write gives a one-cycle pulse, count from data[15:0]
*/
`timescale 1ns/1ps
`include "radio_defines.svh"

module radio_settings #(
  parameter int RADIO_NUM = `RADIO_NUM_DEFAULT
) (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  radio_ctrl_pkg::set_bus_t     i_set,
  input  logic [`RADIO_ADDR_W-1:0]     i_rb_addr,
  input  logic                         i_rb_holdoff,
  input  radio_sample_pkg::vita_time_t i_vita_time,
  input  radio_sample_pkg::sample_t    i_tx_sample,
  input  radio_sample_pkg::sample_t    i_rx_sample,
  output radio_ctrl_pkg::radio_cfg_t   o_cfg,
  output logic                         o_rx_cmd,
  output radio_sample_pkg::len_t       o_rx_count,
  output logic                         o_rb_stb,
  output logic [`RADIO_RB_W-1:0]       o_rb_data
);

  logic cmd_hit;

  // Write to the RX command address
  assign cmd_hit = i_set.stb && (i_set.addr == `RADIO_SR_RX_CMD);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_cfg    <= '0;
      o_rx_cmd <= 1'b0;
    end else begin
      o_rx_cmd <= cmd_hit;
      if (i_set.stb) begin
        case (i_set.addr)
          `RADIO_SR_LOOPBACK:  o_cfg.loopback <= i_set.data[0];
          `RADIO_SR_TEST:      o_cfg.test <= i_set.data;
          `RADIO_SR_IDLE:      o_cfg.idle <= i_set.data;
          `RADIO_SR_RX_MAXLEN: o_cfg.maxlen <= i_set.data[15:0];
          default: ;
        endcase
      end
    end
  end

  // Count travels with the pulse
  always_ff @(posedge i_clk) begin
    if (cmd_hit) begin
      o_rx_count <= i_set.data[15:0];
    end
  end

  always_comb begin
    o_rb_stb = ~i_rb_holdoff;
    case (i_rb_addr)
      `RADIO_RB_TIME: o_rb_data = i_vita_time;
      // Test word next to the live RX sample
      `RADIO_RB_TEST: o_rb_data = {i_rx_sample, o_cfg.test};
      `RADIO_RB_TXRX: o_rb_data = {i_tx_sample, i_rx_sample};
      `RADIO_RB_NUM:  o_rb_data = {32'd0, 32'(RADIO_NUM)};
      default: begin
        o_rb_stb  = 1'b0;
        o_rb_data = '0;
      end
    endcase
  end

endmodule

// File: src/radio_tx_control.sv
/*
  TX burst control
  One stream beat per DAC strobe, ready follows the strobe combinationally
  Idle value drives the DAC between bursts and after an underflow
  No timed commands, every burst starts as soon as data is valid
*/
`timescale 1ns/1ps
`include "radio_defines.svh"

module radio_tx_control (
  input  logic                             i_clk,
  input  logic                             i_reset,
  input  logic                             i_clear,
  input  radio_ctrl_pkg::radio_cfg_t       i_cfg,
  input  radio_sample_pkg::vita_time_t     i_vita_time,
  input  radio_sample_pkg::sid_t [1:0]     i_resp_sid,
  input  radio_sample_pkg::sample_t        i_tx_tdata,
  input  logic                             i_tx_tlast,
  input  logic                             i_tx_tvalid,
  output logic                             o_tx_tready,
  input  logic                             i_tx_stb,
  output radio_sample_pkg::sample_t        o_tx,
  output logic                             o_tx_running,
  output radio_ctrl_pkg::resp_t            o_resp,
  output logic                             o_resp_valid,
  input  logic                             i_resp_ready
);

  radio_ctrl_pkg::tx_state_t state;
  logic consume;
  logic burst_end;

  assign o_tx_running = (state == radio_ctrl_pkg::TX_RUN);
  assign o_tx_tready  = o_tx_running && i_tx_stb;
  assign consume      = o_tx_tready && i_tx_tvalid;
  // Last beat taken or strobe without data
  assign burst_end    = o_tx_tready && (!i_tx_tvalid || i_tx_tlast);
  assign o_resp_valid = (state == radio_ctrl_pkg::TX_RESP);

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      state <= radio_ctrl_pkg::TX_IDLE;
    end else begin
      case (state)
        // Start on valid data, beat stays in the stream
        radio_ctrl_pkg::TX_IDLE: if (i_tx_tvalid) state <= radio_ctrl_pkg::TX_RUN;
        radio_ctrl_pkg::TX_RUN:  if (burst_end) state <= radio_ctrl_pkg::TX_RESP;
        radio_ctrl_pkg::TX_RESP: if (i_resp_ready) state <= radio_ctrl_pkg::TX_IDLE;
        default: state <= radio_ctrl_pkg::TX_IDLE;
      endcase
    end
  end

  // DAC sample changes only on strobes while a burst is active
  always_ff @(posedge i_clk) begin
    if (consume) begin
      o_tx <= i_tx_tdata;
    end else if (state == radio_ctrl_pkg::TX_IDLE || i_tx_stb) begin
      o_tx <= i_cfg.idle;
    end
  end

  // Response stamped when the burst ends
  always_ff @(posedge i_clk) begin
    if (burst_end) begin
      o_resp <= '{code:    i_tx_tvalid ? `RADIO_RESP_ACK : `RADIO_RESP_UNDERFLOW,
                  src:     i_resp_sid[1],
                  dst:     i_resp_sid[0],
                  time_lo: i_vita_time[23:0]};
    end
  end

  // Upstream keeps a waiting beat unchanged until a strobe takes it
  a_tx_stream_hold: assert property (@(posedge i_clk) disable iff (i_reset || i_clear)
    i_tx_tvalid && !o_tx_tready |=>
      i_tx_tvalid && $stable(i_tx_tdata) && $stable(i_tx_tlast));

  // Stalled response holds its word
  a_tx_resp_hold: assert property (@(posedge i_clk) disable iff (i_reset || i_clear)
    o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp));

endmodule

// File: src/radio_rx_sample_counter.sv
/*
  Remaining sample counter for an RX capture
  Packet count reloads from maxlen after each packet
  Maxlen of zero gives packets of 65536 samples
*/
`timescale 1ns/1ps

module radio_rx_sample_counter (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_load,
  input  radio_sample_pkg::len_t i_total,
  input  radio_sample_pkg::len_t i_maxlen,
  input  logic                   i_step,
  output logic                   o_pkt_last,
  output logic                   o_burst_last,
  output logic                   o_empty
);

  radio_sample_pkg::len_t burst_left;
  radio_sample_pkg::len_t pkt_left;

  // Next step takes the final sample
  assign o_pkt_last   = (pkt_left == 16'd1);
  assign o_burst_last = (burst_left == 16'd1);
  assign o_empty      = (burst_left == '0);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      burst_left <= '0;
      pkt_left   <= '0;
    end else begin
      if (i_load) begin
        burst_left <= i_total;
      end else if (i_step) begin
        burst_left <= burst_left - 16'd1;
      end
      // New packet on load and after each closing sample
      if (i_load || (i_step && o_pkt_last)) begin
        pkt_left <= i_maxlen;
      end else if (i_step) begin
        pkt_left <= pkt_left - 16'd1;
      end
    end
  end

  a_no_step_empty: assert property (@(posedge i_clk) disable iff (i_reset)
    i_step |-> !o_empty);

endmodule

// File: src/radio_rx_control.sv
/*
  RX capture control
  Loopback takes the DAC sample and strobe in place of the ADC
  One output register only, a strobe against a stalled beat is an overflow
  Overflow and end of capture both stop the capture and send one response
*/
`timescale 1ns/1ps
`include "radio_defines.svh"

module radio_rx_control (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  logic                         i_clear,
  input  radio_ctrl_pkg::radio_cfg_t   i_cfg,
  input  radio_sample_pkg::vita_time_t i_vita_time,
  input  radio_sample_pkg::sid_t [1:0] i_resp_sid,
  input  logic                         i_cmd,
  input  radio_sample_pkg::len_t       i_count,
  input  radio_sample_pkg::sample_t    i_adc,
  input  logic                         i_adc_stb,
  input  radio_sample_pkg::sample_t    i_tx,
  input  logic                         i_tx_stb,
  output radio_sample_pkg::sample_t    o_rx_tdata,
  output logic                         o_rx_tlast,
  output logic                         o_rx_tvalid,
  input  logic                         i_rx_tready,
  output logic                         o_rx_running,
  output radio_ctrl_pkg::resp_t        o_resp,
  output logic                         o_resp_valid,
  input  logic                         i_resp_ready
);

  radio_ctrl_pkg::rx_state_t state;
  radio_sample_pkg::sample_t sample;
  logic sample_stb;
  logic load;
  logic stall;
  logic take;
  logic step;
  logic overflow;
  logic done;
  logic pkt_last;
  logic burst_last;
  logic empty;

  // Digital loopback TX to RX
  assign sample     = i_cfg.loopback ? i_tx : i_adc;
  assign sample_stb = i_cfg.loopback ? i_tx_stb : i_adc_stb;

  assign o_rx_running = (state == radio_ctrl_pkg::RX_RUN);
  assign o_resp_valid = (state == radio_ctrl_pkg::RX_RESP);
  assign load         = (state == radio_ctrl_pkg::RX_IDLE) && i_cmd;
  assign stall        = o_rx_tvalid && !i_rx_tready;
  // Strobes after the final sample are ignored
  assign take         = o_rx_running && sample_stb && !empty;
  assign step         = take && !stall;
  assign overflow     = take && stall;
  // Capture over once the final beat has left the register
  assign done         = o_rx_running && empty && !o_rx_tvalid;

  radio_rx_sample_counter counter0 (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_load      (load),
    .i_total     (i_count),
    .i_maxlen    (i_cfg.maxlen),
    .i_step      (step),
    .o_pkt_last  (pkt_last),
    .o_burst_last(burst_last),
    .o_empty     (empty)
  );

  always_ff @(posedge i_clk) begin
    if (i_reset || i_clear) begin
      state       <= radio_ctrl_pkg::RX_IDLE;
      o_rx_tvalid <= 1'b0;
    end else begin
      if (step) begin
        o_rx_tvalid <= 1'b1;
      end else if (i_rx_tready) begin
        o_rx_tvalid <= 1'b0;
      end
      case (state)
        radio_ctrl_pkg::RX_IDLE: if (i_cmd) state <= radio_ctrl_pkg::RX_RUN;
        radio_ctrl_pkg::RX_RUN:  if (overflow || done) state <= radio_ctrl_pkg::RX_RESP;
        radio_ctrl_pkg::RX_RESP: if (i_resp_ready) state <= radio_ctrl_pkg::RX_IDLE;
        default: state <= radio_ctrl_pkg::RX_IDLE;
      endcase
    end
  end

  // Beat payload with its packet boundary
  always_ff @(posedge i_clk) begin
    if (step) begin
      o_rx_tdata <= sample;
      o_rx_tlast <= pkt_last || burst_last;
    end
  end

  always_ff @(posedge i_clk) begin
    if (overflow || done) begin
      o_resp <= '{code:    overflow ? `RADIO_RESP_OVERFLOW : `RADIO_RESP_ACK,
                  src:     i_resp_sid[1],
                  dst:     i_resp_sid[0],
                  time_lo: i_vita_time[23:0]};
    end
  end

  // Beat waits unchanged for ready
  a_rx_hold: assert property (@(posedge i_clk) disable iff (i_reset || i_clear)
    stall |=> o_rx_tvalid && $stable(o_rx_tdata) && $stable(o_rx_tlast));

  // New beats come only from a running capture, later ones just drain
  a_rx_source: assert property (@(posedge i_clk) disable iff (i_reset)
    $rose(o_rx_tvalid) |-> $past(state) == radio_ctrl_pkg::RX_RUN);

endmodule

// File: src/radio_resp_mux.sv
/*
  Round-robin merge of the TX and RX response words
  Output is combinational from the granted input, no buffering
  Grant stays put while the granted word is stalled
*/
`timescale 1ns/1ps

module radio_resp_mux (
  input  logic                  i_clk,
  input  logic                  i_reset,
  input  radio_ctrl_pkg::resp_t i_tx_resp,
  input  logic                  i_tx_valid,
  output logic                  o_tx_ready,
  input  radio_ctrl_pkg::resp_t i_rx_resp,
  input  logic                  i_rx_valid,
  output logic                  o_rx_ready,
  output radio_ctrl_pkg::resp_t o_resp,
  output logic                  o_resp_valid,
  input  logic                  i_resp_ready
);

  logic prio_rx;
  logic locked;
  logic locked_rx;
  logic sel_rx;

  // RX wins when alone or when TX won last time
  always_comb begin
    sel_rx       = locked ? locked_rx : (i_rx_valid && (!i_tx_valid || prio_rx));
    o_resp       = sel_rx ? i_rx_resp : i_tx_resp;
    o_resp_valid = sel_rx ? i_rx_valid : i_tx_valid;
    o_tx_ready   = !sel_rx && i_resp_ready;
    o_rx_ready   = sel_rx && i_resp_ready;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      prio_rx   <= 1'b0;
      locked    <= 1'b0;
      locked_rx <= 1'b0;
    end else begin
      locked    <= o_resp_valid && !i_resp_ready;
      locked_rx <= sel_rx;
      // Loser of this transfer goes first next time
      if (o_resp_valid && i_resp_ready) begin
        prio_rx <= !sel_rx;
      end
    end
  end

  a_resp_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp));

endmodule

// File: src/radio_core.sv
/*
  Clock-rate datapath of one radio channel
  RX responses go to the downstream block when the RX response SID is zero
  No timed commands, time only stamped into responses
*/
`timescale 1ns/1ps
`include "radio_defines.svh"

module radio_core #(
  parameter int RADIO_NUM = `RADIO_NUM_DEFAULT
) (
  input  logic                         i_clk,
  input  logic                         i_reset,
  input  logic                         i_clear_rx,
  input  logic                         i_clear_tx,
  input  radio_sample_pkg::sid_t       i_src_sid,
  input  radio_sample_pkg::sid_t       i_dst_sid,
  input  radio_sample_pkg::sid_t       i_rx_resp_dst_sid,
  input  radio_sample_pkg::sid_t       i_tx_resp_dst_sid,
  // ADC and DAC side
  input  radio_sample_pkg::sample_t    i_rx,
  input  logic                         i_rx_stb,
  output logic                         o_rx_running,
  output radio_sample_pkg::sample_t    o_tx,
  input  logic                         i_tx_stb,
  output logic                         o_tx_running,
  input  radio_sample_pkg::vita_time_t i_vita_time,
  // Settings and readback
  input  radio_ctrl_pkg::set_bus_t     i_set,
  input  logic [`RADIO_ADDR_W-1:0]     i_rb_addr,
  input  logic                         i_rb_holdoff,
  output logic                         o_rb_stb,
  output logic [`RADIO_RB_W-1:0]       o_rb_data,
  // Streams
  input  radio_sample_pkg::sample_t    i_tx_tdata,
  input  logic                         i_tx_tlast,
  input  logic                         i_tx_tvalid,
  output logic                         o_tx_tready,
  output radio_sample_pkg::sample_t    o_rx_tdata,
  output logic                         o_rx_tlast,
  output logic                         o_rx_tvalid,
  input  logic                         i_rx_tready,
  output radio_ctrl_pkg::resp_t        o_resp,
  output logic                         o_resp_valid,
  input  logic                         i_resp_ready
);

  radio_ctrl_pkg::radio_cfg_t   cfg;
  radio_ctrl_pkg::resp_t        tx_resp;
  radio_ctrl_pkg::resp_t        rx_resp;
  radio_sample_pkg::len_t       rx_count;
  radio_sample_pkg::sid_t [1:0] tx_resp_sid;
  radio_sample_pkg::sid_t [1:0] rx_resp_sid;
  logic rx_cmd;
  logic tx_resp_valid;
  logic tx_resp_ready;
  logic rx_resp_valid;
  logic rx_resp_ready;

  // Source and destination of each response
  assign tx_resp_sid = {i_src_sid, i_tx_resp_dst_sid};
  assign rx_resp_sid = {i_src_sid, (i_rx_resp_dst_sid != '0) ? i_rx_resp_dst_sid : i_dst_sid};

  radio_settings #(.RADIO_NUM(RADIO_NUM)) settings0 (
    .i_clk(i_clk), .i_reset(i_reset), .i_set(i_set),
    .i_rb_addr(i_rb_addr), .i_rb_holdoff(i_rb_holdoff), .i_vita_time(i_vita_time),
    .i_tx_sample(o_tx), .i_rx_sample(i_rx), .o_cfg(cfg),
    .o_rx_cmd(rx_cmd), .o_rx_count(rx_count), .o_rb_stb(o_rb_stb), .o_rb_data(o_rb_data)
  );

  radio_tx_control tx_control0 (
    .i_clk(i_clk), .i_reset(i_reset), .i_clear(i_clear_tx), .i_cfg(cfg),
    .i_vita_time(i_vita_time), .i_resp_sid(tx_resp_sid),
    .i_tx_tdata(i_tx_tdata), .i_tx_tlast(i_tx_tlast), .i_tx_tvalid(i_tx_tvalid),
    .o_tx_tready(o_tx_tready), .i_tx_stb(i_tx_stb), .o_tx(o_tx), .o_tx_running(o_tx_running),
    .o_resp(tx_resp), .o_resp_valid(tx_resp_valid), .i_resp_ready(tx_resp_ready)
  );

  radio_rx_control rx_control0 (
    .i_clk(i_clk), .i_reset(i_reset), .i_clear(i_clear_rx), .i_cfg(cfg),
    .i_vita_time(i_vita_time), .i_resp_sid(rx_resp_sid), .i_cmd(rx_cmd), .i_count(rx_count),
    .i_adc(i_rx), .i_adc_stb(i_rx_stb), .i_tx(o_tx), .i_tx_stb(i_tx_stb),
    .o_rx_tdata(o_rx_tdata), .o_rx_tlast(o_rx_tlast), .o_rx_tvalid(o_rx_tvalid),
    .i_rx_tready(i_rx_tready), .o_rx_running(o_rx_running),
    .o_resp(rx_resp), .o_resp_valid(rx_resp_valid), .i_resp_ready(rx_resp_ready)
  );

  radio_resp_mux resp_mux0 (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_tx_resp(tx_resp), .i_tx_valid(tx_resp_valid), .o_tx_ready(tx_resp_ready),
    .i_rx_resp(rx_resp), .i_rx_valid(rx_resp_valid), .o_rx_ready(rx_resp_ready),
    .o_resp(o_resp), .o_resp_valid(o_resp_valid), .i_resp_ready(i_resp_ready)
  );

endmodule

// File: sim/radio_core_tb.sv
/*
  Testbench for the radio datapath, driven by sim/radio_core_tests.txt
  Run from the project root so the test file path resolves
  One strobe drives both the DAC and the ADC side, idle sides ignore it
  Loopback taps the DAC register, so RX beat k sees the DAC value before strobe k
*/
`timescale 1ns/1ps
`include "radio_defines.svh"

module radio_core_tb;

  localparam int CHAN = 3;
  localparam logic [15:0] SRC_SID = 16'h0a01;
  localparam logic [15:0] DST_SID = 16'h0b02;
  localparam logic [15:0] RX_DST = 16'h0c03;
  localparam logic [15:0] TX_DST = 16'h0d04;

  // One line of the test file
  typedef struct packed {
    logic [7:0]                kind;
    logic                      loopback;
    radio_sample_pkg::sample_t idle;
    radio_sample_pkg::len_t    maxlen;
    logic [31:0]               test;
    radio_sample_pkg::len_t    len;
    radio_sample_pkg::sample_t first;
    radio_sample_pkg::sample_t step;
    logic [7:0]                spacing;
    logic [7:0]                gap;
    logic [7:0]                tx_code;
    logic [7:0]                rx_code;
  } test_t;

  logic clk;
  logic reset = 1'b1;
  logic clear_rx = 1'b0;
  logic clear_tx = 1'b0;
  radio_sample_pkg::sample_t rx_data = '0;
  logic rx_stb = 1'b0;
  logic tx_stb = 1'b0;
  radio_sample_pkg::vita_time_t vita = '0;
  radio_ctrl_pkg::set_bus_t set_bus = '0;
  logic [7:0] rb_addr = `RADIO_RB_TIME;
  logic rb_holdoff = 1'b1;
  radio_sample_pkg::sample_t tx_tdata = '0;
  logic tx_tlast = 1'b0;
  logic tx_tvalid = 1'b0;
  logic rx_tready = 1'b0;
  logic resp_ready = 1'b1;
  radio_sample_pkg::sample_t o_tx;
  radio_sample_pkg::sample_t o_rx_tdata;
  radio_ctrl_pkg::resp_t o_resp;
  logic [63:0] o_rb_data;
  logic o_rx_running, o_tx_running, o_rb_stb, o_tx_tready;
  logic o_rx_tlast, o_rx_tvalid, o_resp_valid;

  test_t tests[$];
  radio_ctrl_pkg::resp_t resp_q[$];
  logic [32:0] beat_q[$];
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int limit = 0;
  logic rdy_hold = 1'b0;
  int rdy_gap = 0;
  int rdy_wait = 0;

  radio_core #(.RADIO_NUM(CHAN)) dut0 (
    .i_clk(clk), .i_reset(reset), .i_clear_rx(clear_rx), .i_clear_tx(clear_tx),
    .i_src_sid(SRC_SID), .i_dst_sid(DST_SID),
    .i_rx_resp_dst_sid(RX_DST), .i_tx_resp_dst_sid(TX_DST),
    .i_rx(rx_data), .i_rx_stb(rx_stb), .o_rx_running(o_rx_running),
    .o_tx(o_tx), .i_tx_stb(tx_stb), .o_tx_running(o_tx_running), .i_vita_time(vita),
    .i_set(set_bus), .i_rb_addr(rb_addr), .i_rb_holdoff(rb_holdoff),
    .o_rb_stb(o_rb_stb), .o_rb_data(o_rb_data),
    .i_tx_tdata(tx_tdata), .i_tx_tlast(tx_tlast), .i_tx_tvalid(tx_tvalid),
    .o_tx_tready(o_tx_tready),
    .o_rx_tdata(o_rx_tdata), .o_rx_tlast(o_rx_tlast), .o_rx_tvalid(o_rx_tvalid),
    .i_rx_tready(rx_tready),
    .o_resp(o_resp), .o_resp_valid(o_resp_valid), .i_resp_ready(resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Free running time and the run watchdog
  always @(posedge clk) begin
    vita <= vita + 64'd1;
    cycles <= cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: run passed its limit of %0d cycles", limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // RX ready, low for at most rdy_gap cycles in a row
  always @(posedge clk) begin
    if (rdy_hold) begin
      rx_tready <= 1'b0;
    end else if (rdy_wait == 0) begin
      rx_tready <= 1'b1;
      rdy_wait <= (rdy_gap == 0) ? 0 : int'($urandom % (rdy_gap + 1));
    end else begin
      rx_tready <= 1'b0;
      rdy_wait <= rdy_wait - 1;
    end
  end

  // Transfers are stable between edges
  always @(negedge clk) begin
    if (!reset && o_resp_valid && resp_ready) resp_q.push_back(o_resp);
    if (!reset && o_rx_tvalid && rx_tready) beat_q.push_back({o_rx_tlast, o_rx_tdata});
  end

  task automatic report_error(input string what);
    errors++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Sample k of a ramp
  function automatic radio_sample_pkg::sample_t burst_sample(input test_t t, input int k);
    return t.first + radio_sample_pkg::sample_t'(k) * t.step;
  endfunction

  task automatic write_setting(input logic [7:0] set_addr, input logic [31:0] set_data);
    @(posedge clk);
    set_bus <= '{stb: 1'b1, addr: set_addr, data: set_data};
    @(posedge clk);
    set_bus <= '0;
  endtask

  task automatic load_tests;
    int fd;
    int n;
    int unsigned f[12];
    string line;
    fd = $fopen("sim/radio_core_tests.txt", "r");
    assert (fd != 0) else report_error("cannot open sim/radio_core_tests.txt");
    if (fd != 0) begin
      while ($fgets(line, fd) > 0) begin
        if (line.len() > 1 && line.getc(0) != 8'h23) begin
          n = $sscanf(line, "%d %d %h %d %h %d %h %h %d %d %h %h", f[0], f[1], f[2], f[3],
                      f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11]);
          assert (n == 12) else report_error({"bad test line: ", line});
          if (n == 12) begin
            tests.push_back('{f[0][7:0], f[1][0], f[2], f[3][15:0], f[4], f[5][15:0], f[6],
                              f[7], f[8][7:0], f[9][7:0], f[10][7:0], f[11][7:0]});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_readback(input logic [31:0] test_word,
                                input radio_sample_pkg::sample_t idle_word);
    radio_sample_pkg::sample_t live;
    // RX input with swapped halves so it differs from the test word
    live = {test_word[15:0], test_word[31:16]};
    @(posedge clk);
    rx_data <= live;
    rb_addr <= `RADIO_RB_TEST;
    rb_holdoff <= 1'b0;
    @(negedge clk);
    check("o_rb_data test", o_rb_data, {live, test_word});
    check("o_rb_stb", o_rb_stb, 1'b1);
    // DAC shows the idle value between bursts
    @(posedge clk);
    rb_addr <= `RADIO_RB_TXRX;
    @(negedge clk);
    check("o_rb_data txrx", o_rb_data, {idle_word, live});
    @(posedge clk);
    rb_addr <= `RADIO_RB_NUM;
    @(negedge clk);
    check("o_rb_data num", o_rb_data, 64'(CHAN));
    @(posedge clk);
    rb_addr <= `RADIO_RB_TIME;
    @(negedge clk);
    check("o_rb_data time", o_rb_data, vita);
    @(posedge clk);
    rb_holdoff <= 1'b1;
    @(negedge clk);
    check("o_rb_stb holdoff", o_rb_stb, 1'b0);
    // Unused address reads as zero
    @(posedge clk);
    rb_addr <= 8'h77;
    rb_holdoff <= 1'b0;
    @(negedge clk);
    check("o_rb_data unknown", o_rb_data, 64'd0);
    check("o_rb_stb unknown", o_rb_stb, 1'b0);
    @(posedge clk);
    rb_addr <= `RADIO_RB_TIME;
    rb_holdoff <= 1'b1;
  endtask

  task automatic check_responses(input test_t t,
                                 input radio_sample_pkg::vita_time_t tx_stamp);
    int k;
    int tx_seen;
    int rx_seen;
    logic known;
    tx_seen = 0;
    rx_seen = 0;
    for (k = 0; k < resp_q.size(); k++) begin
      check("o_resp.src", resp_q[k].src, SRC_SID);
      known = 1'b1;
      if (resp_q[k].dst == TX_DST && t.tx_code != 8'hff) begin
        tx_seen++;
        check("o_resp.code tx", resp_q[k].code, t.tx_code);
        // Stamped on the strobe that ended the burst
        check("o_resp.time_lo tx", resp_q[k].time_lo, tx_stamp[23:0]);
      end else if (resp_q[k].dst == RX_DST && t.rx_code != 8'hff) begin
        rx_seen++;
        check("o_resp.code rx", resp_q[k].code, t.rx_code);
      end else begin
        known = 1'b0;
      end
      assert (known) else report_error($sformatf("unexpected response word %h", resp_q[k]));
    end
    check("TX responses", tx_seen, (t.tx_code != 8'hff) ? 1 : 0);
    check("RX responses", rx_seen, (t.rx_code != 8'hff) ? 1 : 0);
  endtask

  task automatic run_test(input test_t t, input int num);
    int errs_before;
    int nstb;
    int nexp;
    int waited;
    int i;
    logic uf;
    logic tx_on;
    logic rx_on;
    radio_sample_pkg::sample_t exp_data;
    logic exp_last;
    radio_sample_pkg::vita_time_t tx_stamp;
    errs_before = errors;
    tx_stamp = '0;
    uf = (t.kind == 2) || (t.kind == 5);
    tx_on = (t.kind == 1) || (t.kind == 2) || (t.kind == 4) || (t.kind == 5);
    rx_on = (t.kind >= 3);
    // An underflow needs one strobe past the data
    nstb = int'(t.len) + (uf ? 1 : 0);
    nexp = ((t.tx_code != 8'hff) ? 1 : 0) + ((t.rx_code != 8'hff) ? 1 : 0);
    beat_q.delete();
    resp_q.delete();
    write_setting(`RADIO_SR_LOOPBACK, {31'd0, t.loopback});
    write_setting(`RADIO_SR_IDLE, t.idle);
    write_setting(`RADIO_SR_RX_MAXLEN, {16'd0, t.maxlen});
    write_setting(`RADIO_SR_TEST, t.test);
    @(negedge clk);
    check("o_tx idle", o_tx, t.idle);
    if (t.kind == 0) check_readback(t.test, t.idle);
    @(posedge clk);
    rdy_hold <= (t.kind == 5);
    rdy_gap <= int'(t.gap);
    resp_ready <= (t.kind != 5);
    if (rx_on) begin
      write_setting(`RADIO_SR_RX_CMD, {16'd0, t.len});
      waited = 0;
      @(negedge clk);
      while (!o_rx_running && waited < 20) begin
        @(negedge clk);
        waited++;
      end
      assert (o_rx_running) else report_error("RX capture did not start");
    end
    if (tx_on) begin
      @(posedge clk);
      tx_tvalid <= 1'b1;
      tx_tdata <= t.first;
      tx_tlast <= (t.len == 1) && !uf;
    end
    for (i = 0; i < nstb; i++) begin
      @(posedge clk);
      tx_stb <= 1'b1;
      rx_stb <= 1'b1;
      rx_data <= burst_sample(t, i);
      @(negedge clk);
      check("o_tx_tready", o_tx_tready, tx_on);
      // Time seen by the DUT on this strobe
      tx_stamp = vita;
      @(posedge clk);
      tx_stb <= 1'b0;
      rx_stb <= 1'b0;
      if (tx_on && i + 1 < int'(t.len)) begin
        tx_tdata <= burst_sample(t, i + 1);
        tx_tlast <= (i + 2 == int'(t.len)) && !uf;
      end else begin
        tx_tvalid <= 1'b0;
        tx_tlast <= 1'b0;
      end
      @(negedge clk);
      // Underflow drops the DAC back to idle
      if (tx_on) check("o_tx", o_tx, (i < int'(t.len)) ? burst_sample(t, i) : t.idle);
      repeat (int'(t.spacing) - 2) @(posedge clk);
    end
    if (t.kind == 5) begin
      // Both responses wait on the stalled port
      repeat (2) @(negedge clk);
      check("o_resp_valid stalled", o_resp_valid, 1'b1);
      @(posedge clk);
      resp_ready <= 1'b1;
    end
    waited = 0;
    while (resp_q.size() < nexp && waited < 400) begin
      @(negedge clk);
      waited++;
    end
    repeat (4) @(negedge clk);
    check("response count", resp_q.size(), nexp);
    check_responses(t, tx_stamp);
    if (t.kind == 3 || t.kind == 4) begin
      check("beat count", beat_q.size(), t.len);
      for (i = 0; i < beat_q.size() && i < int'(t.len); i++) begin
        if (t.kind == 4) exp_data = (i == 0) ? t.idle : burst_sample(t, i - 1);
        else exp_data = burst_sample(t, i);
        exp_last = ((i + 1) % int'(t.maxlen) == 0) || (i + 1 == int'(t.len));
        check($sformatf("o_rx_tdata[%0d]", i), beat_q[i][31:0], exp_data);
        check($sformatf("o_rx_tlast[%0d]", i), beat_q[i][32], exp_last);
      end
    end
    if (t.kind == 5) begin
      @(posedge clk);
      rdy_hold <= 1'b0;
      repeat (4) @(posedge clk);
    end
    @(negedge clk);
    check("o_tx end", o_tx, t.idle);
    check("o_tx_running", o_tx_running, 1'b0);
    check("o_rx_running", o_rx_running, 1'b0);
    $display("Test %0d kind %0d: %s (%0d errors)", num, t.kind,
             (errors == errs_before) ? "ok" : "failed", errors - errs_before);
  endtask

  initial begin
    int k;
    int budget;
    void'($urandom(32'hfad043dd));
    load_tests();
    assert (tests.size() > 0) else report_error("no tests were read");
    // Strobes of every test plus setup and drain per test
    budget = 40;
    foreach (tests[k]) budget += (int'(tests[k].len) + 2) * int'(tests[k].spacing) + 400;
    limit = budget;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(negedge clk);
    check("o_resp_valid after reset", o_resp_valid, 1'b0);
    check("responses after reset", resp_q.size(), 0);
    check("o_tx_running after reset", o_tx_running, 1'b0);
    check("o_rx_running after reset", o_rx_running, 1'b0);
    check("o_rx_tvalid after reset", o_rx_tvalid, 1'b0);
    check("o_tx_tready after reset", o_tx_tready, 1'b0);
    check("o_rb_stb after reset", o_rb_stb, 1'b0);
    for (k = 0; k < tests.size(); k++) begin
      run_test(tests[k], k);
      repeat (4) @(posedge clk);
    end
    $display("Tests run %0d, checks %0d, errors %0d", tests.size(), checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sim/radio_core_tests.txt
# kind loopback idle maxlen test len first step spacing rx_ready_gap tx_code rx_code
# kinds 0 readback, 1 TX burst, 2 TX underflow, 3 RX capture, 4 loopback, 5 RX overflow; ff = none
0 0 00000000 8 a5a5c3c3 0 00000000 00000000 2 0 ff ff
0 0 00000000 8 0000ffff 0 00000000 00000000 2 0 ff ff
1 0 7fff8000 8 00000000 6 00010002 00010001 3 0 00 ff
1 0 00000000 8 00000000 1 12345678 00000000 2 0 00 ff
1 0 00400040 8 00000000 4 80008000 00100010 2 0 00 ff
2 0 11112222 8 00000000 3 00100010 00000100 4 0 01 ff
2 0 00000000 8 00000000 1 0000beef 00000000 3 0 01 ff
3 0 00000000 4 00000000 10 00000000 00010001 4 2 ff 00
3 0 00000000 3 00000000 7 80008000 fffffffe 5 3 ff 00
3 0 00000000 16 00000000 5 0000aaaa 00000003 2 0 ff 00
3 0 00000000 1 00000000 3 00050005 00000001 3 1 ff 00
4 1 55550000 4 00000000 8 01000100 00020002 3 1 00 00
4 1 00000000 2 00000000 5 0000f000 00000010 4 2 00 00
5 0 00000000 8 00000000 4 00200020 00000001 3 0 01 08
5 0 00000000 2 00000000 3 00300030 00000002 4 0 01 08

// File: filelist.f
+incdir+src
src/radio_sample_pkg.sv
src/radio_ctrl_pkg.sv
src/radio_settings.sv
src/radio_tx_control.sv
src/radio_rx_sample_counter.sv
src/radio_rx_control.sv
src/radio_resp_mux.sv
src/radio_core.sv
sim/radio_core_tb.sv

// File: Makefile
# Verilator build and run of the radio datapath testbench
TOP = radio_core_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
